//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -Wno-fatal
TOP      := mem_check_tb
FILELIST := mem_check.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- mem_check.f
source/mem_check_pkg.sv
source/access_dispatch.sv
source/mem_test_bank.sv
source/error_collect.sv
source/mem_check_top.sv
tb/mem_check_monitor.sv
tb/mem_check_tb.sv

//--- source/access_dispatch.sv
// Access dispatcher, turns a four-phase request into one strobe to the addressed bank
`timescale 1ns/1ps

module access_dispatch #(
  parameter int NUM_BANKS = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req,
  input  mem_check_pkg::access_req_t  request,
  output logic [NUM_BANKS-1:0]        strobe,
  output mem_check_pkg::bank_access_t bank_access
);

  import mem_check_pkg::*;

  // Upper address bits pick the bank
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);

  dispatch_state_t state;
  dispatch_state_t state_next;

  logic [BANK_SEL_W-1:0] bank_sel;
  logic [NUM_BANKS-1:0]  bank_onehot;

  assign bank_sel = request.addr[ADDR_W-1 -: BANK_SEL_W];

  always_comb begin
    bank_onehot = '0;
    bank_onehot[bank_sel] = 1'b1;
  end

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_next = ISSUE;
        end
      end
      ISSUE: begin
        state_next = WAIT_RELEASE;
      end
      WAIT_RELEASE: begin
        // Host keeps req high until it sees ack, so no second issue
        if (!req) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Strobe is a single-cycle pulse leaving ISSUE
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      strobe <= '0;
    end else if (state == ISSUE) begin
      strobe <= bank_onehot;
    end else begin
      strobe <= '0;
    end
  end

  // Request payload captured alongside the strobe
  always_ff @(posedge clk) begin
    if (state == ISSUE) begin
      bank_access.addr  <= request.addr;
      bank_access.wdata <= request.wdata;
    end
  end

endmodule

//--- source/error_collect.sv
// Result collector, answers the host on ack and keeps mismatch statistics
`timescale 1ns/1ps

module error_collect #(
  parameter int NUM_BANKS = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req,
  input  logic [NUM_BANKS-1:0]        result_valid,
  input  mem_check_pkg::bank_result_t results [NUM_BANKS],
  output logic                        ack,
  output mem_check_pkg::access_rsp_t  response,
  output mem_check_pkg::err_count_t   err_count,
  output mem_check_pkg::addr_t        last_err_addr,
  output logic                        err_seen
);

  import mem_check_pkg::*;

  logic         any_valid;
  bank_result_t sel_result;
  logic         req_q;
  logic         new_error;

  assign any_valid = |result_valid;

  // At most one bank reports at a time, so an OR of the gated results works
  always_comb begin
    sel_result = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (result_valid[i]) begin
        sel_result = sel_result | results[i];
      end
    end
  end

  assign new_error = any_valid && sel_result.mismatch;

  // Registered req for the falling phase
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // ack rises with the result, drops the edge after req is seen low
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack <= 1'b0;
    end else if (any_valid) begin
      ack <= 1'b1;
    end else if (ack && !req_q) begin
      ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (any_valid) begin
      response.old_data <= sel_result.old_data;
      response.mismatch <= sel_result.mismatch;
    end
  end

  // Error statistics
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      err_count     <= '0;
      last_err_addr <= '0;
      err_seen      <= 1'b0;
    end else if (new_error) begin
      // Counter saturates at all ones
      if (err_count != '1) begin
        err_count <= err_count + 1'b1;
      end
      last_err_addr <= sel_result.addr;
      err_seen      <= 1'b1;
    end
  end

endmodule

//--- source/mem_check_pkg.sv
// Banked memory checker types shared by dispatcher, banks and collector
package mem_check_pkg;

  // Global address space and word size
  localparam int ADDR_W  = 8;
  localparam int DATA_W  = 8;
  localparam int ERR_CNT_W = 16;
  localparam int NUM_WORDS = 1 << ADDR_W;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [ERR_CNT_W-1:0] err_count_t;

  // Host request, held stable while req is high
  typedef struct packed {
    addr_t addr;
    data_t wdata;
  } access_req_t;

  // Access broadcast to all banks, qualified by a per-bank strobe
  typedef struct packed {
    addr_t addr;
    data_t wdata;
  } bank_access_t;

  // Registered bank outcome, carries the full address for error logging
  typedef struct packed {
    addr_t addr;
    data_t old_data;
    logic  mismatch;
  } bank_result_t;

  // Response to the host, valid while ack is high
  typedef struct packed {
    data_t old_data;
    logic  mismatch;
  } access_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RELEASE
  } dispatch_state_t;

endpackage

//--- source/mem_check_top.sv
// Banked memory checker top, dispatcher feeding NUM_BANKS compare banks and a collector
`timescale 1ns/1ps

module mem_check_top #(
  parameter int NUM_BANKS = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  input  mem_check_pkg::access_req_t request,
  output logic                       ack,
  output mem_check_pkg::access_rsp_t response,
  output mem_check_pkg::err_count_t  err_count,
  output mem_check_pkg::addr_t       last_err_addr,
  output logic                       err_seen
);

  import mem_check_pkg::*;

  logic [NUM_BANKS-1:0] bank_strobe;
  bank_access_t         bank_access;

  logic [NUM_BANKS-1:0] bank_valid;
  bank_result_t         bank_results [NUM_BANKS];

  // Request decode and strobe generation
  access_dispatch #(
    .NUM_BANKS (NUM_BANKS)
  ) dispatch_i (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .request     (request),
    .strobe      (bank_strobe),
    .bank_access (bank_access)
  );

  // One compare bank per address slice
  for (genvar i = 0; i < NUM_BANKS; i++) begin : bank_g
    mem_test_bank #(
      .NUM_BANKS (NUM_BANKS)
    ) bank_i (
      .clk          (clk),
      .rst          (rst),
      .strobe       (bank_strobe[i]),
      .bank_access  (bank_access),
      .result_valid (bank_valid[i]),
      .result       (bank_results[i])
    );
  end

  // Response path and statistics
  error_collect #(
    .NUM_BANKS (NUM_BANKS)
  ) collect_i (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .result_valid  (bank_valid),
    .results       (bank_results),
    .ack           (ack),
    .response      (response),
    .err_count     (err_count),
    .last_err_addr (last_err_addr),
    .err_seen      (err_seen)
  );

endmodule

//--- source/mem_test_bank.sv
// Compare bank, reads the stored word, writes new data and flags a changed rewrite
`timescale 1ns/1ps

module mem_test_bank #(
  parameter int NUM_BANKS = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        strobe,
  input  mem_check_pkg::bank_access_t bank_access,
  output logic                        result_valid,
  output mem_check_pkg::bank_result_t result
);

  import mem_check_pkg::*;

  // Each bank owns an equal slice of the global address space
  localparam int BANK_DEPTH = NUM_WORDS / NUM_BANKS;
  localparam int WORD_W     = $clog2(BANK_DEPTH);

  data_t                 mem [BANK_DEPTH];
  logic [BANK_DEPTH-1:0] written;

  logic [WORD_W-1:0] word_idx;
  data_t             stored;
  logic              was_written;
  data_t             old_data;
  logic              mismatch;

  // Lower address bits select the word inside the bank
  assign word_idx = bank_access.addr[WORD_W-1:0];

  assign stored      = mem[word_idx];
  assign was_written = written[word_idx];

  // Never-written words read back as zero
  assign old_data = was_written ? stored : '0;

  // Only a rewrite with different data counts as a mismatch
  assign mismatch = was_written && (stored != bank_access.wdata);

  // Storage array, read above happens before this write lands
  always_ff @(posedge clk) begin
    if (strobe) begin
      mem[word_idx] <= bank_access.wdata;
    end
  end

  // Written flags
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      written <= '0;
    end else if (strobe) begin
      written[word_idx] <= 1'b1;
    end
  end

  // Result pulse, one cycle after the strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (strobe) begin
      result.addr     <= bank_access.addr;
      result.old_data <= old_data;
      result.mismatch <= mismatch;
    end
  end

endmodule

//--- tb/mem_check_monitor.sv
// Memory checker monitor, reference model of the banked memory and response comparison
`timescale 1ns/1ps

module mem_check_monitor (
  input logic                       clk,
  input logic                       rst,
  input logic                       req,
  input mem_check_pkg::access_req_t request,
  input logic                       ack,
  input mem_check_pkg::access_rsp_t response,
  input mem_check_pkg::err_count_t  err_count,
  input mem_check_pkg::addr_t       last_err_addr,
  input logic                       err_seen
);

  import mem_check_pkg::*;

  // Reference state
  data_t      model_mem [NUM_WORDS];
  logic       model_written [NUM_WORDS];
  err_count_t model_count;
  addr_t      model_last;
  logic       model_seen;

  int          error_count = 0;
  int          update_count = 0;
  int unsigned req_age = 0;
  int unsigned rel_age = 0;
  logic        req_prev = 1'b0;
  logic        ack_prev = 1'b0;
  logic        served = 1'b0;

  task automatic check_field(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected 0x%h got 0x%h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic protocol_error(input string msg);
    $display("Protocol error at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic clear_model();
    for (int i = 0; i < NUM_WORDS; i++) begin
      model_written[i] = 1'b0;
    end
    model_count = '0;
    model_last  = '0;
    model_seen  = 1'b0;
  endtask

  // One read-then-write access, then compare everything the DUT reports
  task automatic model_access(input access_req_t acc);
    data_t exp_old;
    logic  exp_mm;
    exp_old = model_written[acc.addr] ? model_mem[acc.addr] : '0;
    exp_mm  = model_written[acc.addr] && (model_mem[acc.addr] != acc.wdata);
    model_mem[acc.addr]     = acc.wdata;
    model_written[acc.addr] = 1'b1;
    if (exp_mm) begin
      if (model_count != '1) begin
        model_count = model_count + 16'd1;
      end
      model_last = acc.addr;
      model_seen = 1'b1;
    end
    check_field("response.old_data", 16'(exp_old), 16'(response.old_data));
    check_field("response.mismatch", 16'(exp_mm), 16'(response.mismatch));
    check_field("err_count", model_count, err_count);
    check_field("last_err_addr", 16'(model_last), 16'(last_err_addr));
    check_field("err_seen", 16'(model_seen), 16'(err_seen));
    update_count++;
  endtask

  // Outputs settle after the rising edge, so compare on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      clear_model();
      req_prev = 1'b0;
      ack_prev = 1'b0;
      served   = 1'b0;
      check_field("ack", 16'd0, 16'(ack));
      check_field("err_count", 16'd0, err_count);
      check_field("last_err_addr", 16'd0, 16'(last_err_addr));
      check_field("err_seen", 16'd0, 16'(err_seen));
    end else begin
      if (req && !req_prev) begin
        req_age = 0;
        served  = 1'b0;
      end else begin
        req_age++;
      end
      if (!req && req_prev) begin
        rel_age = 0;
      end else begin
        rel_age++;
      end
      if (ack && !ack_prev) begin
        // Host may already have dropped req right after the edge that raised ack
        if (!req && !req_prev) begin
          protocol_error("ack rose with no open request");
        end else if (served) begin
          protocol_error("ack rose twice within one request");
        end else begin
          // req seen one half cycle ahead of the edge that samples it
          if (req_age != 4) begin
            $display("Protocol error at %0t ns: req to ack took %0d cycles instead of 3",
                     $time, req_age - 1);
            error_count++;
          end
          model_access(request);
          served = 1'b1;
        end
      end
      if (!ack && ack_prev) begin
        if (req) begin
          protocol_error("ack fell while req was still high");
        end else if (rel_age != 2) begin
          $display("Protocol error at %0t ns: ack fell %0d cycles after req release, not 1",
                   $time, rel_age - 1);
          error_count++;
        end
      end
      req_prev = req;
      ack_prev = ack;
    end
  end

endmodule

//--- tb/mem_check_tb.sv
// Memory checker testbench, seeded host traffic over the four-phase handshake
`timescale 1ns/1ps

module mem_check_tb;

  import mem_check_pkg::*;

  localparam int NUM_BANKS   = 4;
  localparam int CLK_PERIOD  = 8;
  localparam int FIRST_OPS   = 16;
  localparam int RANDOM_OPS  = 400;
  localparam int HOLD_OPS    = 40;
  localparam int TOTAL_OPS   = 4 * FIRST_OPS + RANDOM_OPS + HOLD_OPS + 1;
  localparam int ACK_LIMIT   = 20;
  localparam int WATCHDOG_NS = TOTAL_OPS * 12 * CLK_PERIOD + 1000;

  logic        clk;
  logic        rst;
  logic        req;
  access_req_t request;
  logic        ack;
  access_rsp_t response;
  err_count_t  err_count;
  addr_t       last_err_addr;
  logic        err_seen;

  int    seed;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    tb_errors = 0;
  int    txn_count = 0;
  addr_t first_addr [FIRST_OPS];
  data_t first_data [FIRST_OPS];
  // Few distinct values so rewrites often repeat or change the data
  data_t value_set [4] = '{8'h00, 8'h3c, 8'ha5, 8'hff};

  mem_check_top #(
    .NUM_BANKS (NUM_BANKS)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .request       (request),
    .ack           (ack),
    .response      (response),
    .err_count     (err_count),
    .last_err_addr (last_err_addr),
    .err_seen      (err_seen)
  );

  mem_check_monitor mon_i (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .request       (request),
    .ack           (ack),
    .response      (response),
    .err_count     (err_count),
    .last_err_addr (last_err_addr),
    .err_seen      (err_seen)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  function automatic int error_total();
    return mon_i.error_count + tb_errors;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    req = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // Raise req with a new request and wait for ack
  task automatic open_access(input addr_t addr, input data_t data);
    int waited;
    @(posedge clk);
    #1;
    request.addr  = addr;
    request.wdata = data;
    req = 1'b1;
    waited = 0;
    while (!ack && waited < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ack) begin
      $display("No ack within %0d cycles for address 0x%h", ACK_LIMIT, addr);
      tb_errors++;
    end
    txn_count++;
  endtask

  // Full four-phase transaction, req held for extra cycles after ack
  task automatic run_access(input addr_t addr, input data_t data, input int hold);
    int waited;
    open_access(addr, data);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    waited = 0;
    while (ack && waited < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (ack) begin
      $display("ack stayed high %0d cycles after req was released", ACK_LIMIT);
      tb_errors++;
    end
  endtask

  task automatic close_test(input string name, input int base);
    int errors;
    if (mon_i.update_count != txn_count) begin
      $display("Monitor saw %0d updates for %0d transactions", mon_i.update_count, txn_count);
      tb_errors++;
    end
    errors = error_total() - base;
    if (errors == 0) begin
      $display("Test %s: passed", name);
      tests_passed++;
    end else begin
      $display("Test %s: failed with %0d errors", name, errors);
      tests_failed++;
    end
  endtask

  initial begin
    int base;
    int r;
    seed    = 32'h7d5e_4318;
    rst     = 1'b1;
    req     = 1'b0;
    request = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // One address per 16-word stride, spread over all banks
    base = error_total();
    for (int i = 0; i < FIRST_OPS; i++) begin
      first_addr[i] = addr_t'(i * 16 + i);
      first_data[i] = data_t'($random(seed));
      run_access(first_addr[i], first_data[i], 0);
    end
    close_test("first_writes", base);

    base = error_total();
    for (int i = 0; i < FIRST_OPS; i++) begin
      run_access(first_addr[i], first_data[i], 0);
    end
    close_test("rewrite_equal", base);

    base = error_total();
    for (int i = 0; i < FIRST_OPS; i++) begin
      first_data[i] = first_data[i] ^ 8'h5a;
      run_access(first_addr[i], first_data[i], 0);
    end
    close_test("rewrite_different", base);

    // 32 addresses, eight per bank
    base = error_total();
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r = $random(seed);
      run_access({r[1:0], 3'b000, r[4:2]}, value_set[r[6:5]], 0);
    end
    close_test("random_stream", base);

    base = error_total();
    for (int i = 0; i < HOLD_OPS; i++) begin
      r = $random(seed);
      run_access(addr_t'(r), value_set[r[9:8]], $unsigned($random(seed)) % 6);
    end
    close_test("handshake_timing", base);

    // Reset lands while ack is still high
    base = error_total();
    open_access(first_addr[0], data_t'($random(seed)));
    apply_reset();
    for (int i = 0; i < FIRST_OPS; i++) begin
      run_access(first_addr[i], data_t'($random(seed)), 0);
    end
    close_test("mid_run_reset", base);

    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_total() == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
